// ==== all.f ====
+incdir+design
design/pipePkg.sv
design/recordPacker.sv
design/ramBlock.sv
design/fastFifo.sv
design/runningSum.sv
design/recordPipe.sv
verif/recordPipeTb.sv

// ==== design/fastFifo.sv ====
`timescale 1ns/1ps

`include "pipe_defs.svh"

// zero read latency: dataOutValid comes back in the cycle of readRequest
module fastFifo #(
    parameter type payloadT = logic [31:0]
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        writeEnable,
    input  payloadT                     dataIn,
    input  logic                        readRequest,
    output payloadT                     dataOut,
    output logic                        dataOutValid,
    output logic [`FIFO_DEPTH_LOG2-1:0] level
);

    logic [`FIFO_DEPTH_LOG2-1:0] writeAddr;
    logic [`FIFO_DEPTH_LOG2-1:0] nextReadAddr;
    logic [`FIFO_DEPTH_LOG2-1:0] validUpTo;
    logic hasData;
    logic isReading;

    assign hasData = validUpTo != nextReadAddr;
    assign isReading = readRequest && hasData;
    assign dataOutValid = isReading;
    assign level = validUpTo - nextReadAddr; // wraps

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            writeAddr <= '0;
            nextReadAddr <= `FIFO_DEPTH_LOG2'(1); // one ahead, RAM read reg sits at 0
            validUpTo <= `FIFO_DEPTH_LOG2'(1);
        end else begin
            // lags a cycle to match the RAM write delay
            validUpTo <= writeAddr + 1'b1;
            if (writeEnable) writeAddr <= writeAddr + 1'b1;
            if (isReading) nextReadAddr <= nextReadAddr + 1'b1;
        end
    end

    // each read preloads the following head address
    ramBlock #(
        .payloadT(payloadT)
    ) ram_i (
        .clk(clk),
        .rst(rst),
        .writeEnable(writeEnable),
        .writeAddr(writeAddr),
        .dataIn(dataIn),
        .readAddressStall(!isReading),
        .readAddr(nextReadAddr),
        .dataOut(dataOut)
    );

endmodule

// ==== design/pipePkg.sv ====
`include "pipe_defs.svh"

package pipePkg;

    // one buffered record, 32 bits
    typedef struct packed {
        logic [`SEQ_WIDTH-1:0] seq;     // input order, wraps
        logic [`KEY_WIDTH-1:0] key;
        logic [`VALUE_WIDTH-1:0] value; // unsigned
    } recordT;

    // running total, wraps modulo 2^SUM_WIDTH
    typedef logic [`SUM_WIDTH-1:0] sumT;

endpackage

// ==== design/pipe_defs.svh ====
`ifndef PIPE_DEFS_SVH
`define PIPE_DEFS_SVH

// fifo sizing, 32 RAM entries
`define FIFO_DEPTH_LOG2 5

// leaves room for writes the level does not show yet
`define DROP_LEVEL 28

`define KEY_WIDTH 8
`define VALUE_WIDTH 16
`define SEQ_WIDTH 8
`define SUM_WIDTH 24

`endif

// ==== design/ramBlock.sv ====
`timescale 1ns/1ps

`include "pipe_defs.svh"

module ramBlock #(
    parameter type payloadT = logic [31:0]
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        writeEnable,
    input  logic [`FIFO_DEPTH_LOG2-1:0] writeAddr,
    input  payloadT                     dataIn,
    input  logic                        readAddressStall,
    input  logic [`FIFO_DEPTH_LOG2-1:0] readAddr,
    output payloadT                     dataOut
);

    localparam int Depth = 1 << `FIFO_DEPTH_LOG2;

    payloadT memory [0:Depth-1];

    logic [`FIFO_DEPTH_LOG2-1:0] writeAddrReg;
    payloadT writeDataReg;
    logic writeEnableReg;
    logic [`FIFO_DEPTH_LOG2-1:0] readAddrReg;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            writeEnableReg <= 1'b0;
            readAddrReg <= '0;
        end else begin
            writeEnableReg <= writeEnable;
            if (!readAddressStall) readAddrReg <= readAddr; // holds while stalled
        end
    end

    // write path lands one clock late
    always_ff @(posedge clk) begin
        writeAddrReg <= writeAddr;
        writeDataReg <= dataIn;
        if (writeEnableReg) begin
            memory[writeAddrReg] <= writeDataReg;
        end
    end

    assign dataOut = memory[readAddrReg];

endmodule

// ==== design/recordPacker.sv ====
`timescale 1ns/1ps

`include "pipe_defs.svh"

module recordPacker (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        inValid,
    input  logic [`KEY_WIDTH-1:0]       inKey,
    input  logic [`VALUE_WIDTH-1:0]     inValue,
    input  logic [`FIFO_DEPTH_LOG2-1:0] level,
    output logic                        writeEnable,
    output pipePkg::recordT             dataIn,
    output logic [15:0]                 dropCount
);

    logic [`SEQ_WIDTH-1:0] seqCount;
    logic dropNow;

    // fifo too full to take another record
    assign dropNow = level >= `FIFO_DEPTH_LOG2'(`DROP_LEVEL);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seqCount <= '0;
            writeEnable <= 1'b0;
            dropCount <= '0;
        end else begin
            writeEnable <= inValid && !dropNow;
            if (inValid) begin
                seqCount <= seqCount + 1'b1; // dropped records still use a number
                if (dropNow && dropCount != '1) begin
                    dropCount <= dropCount + 1'b1; // saturates
                end
            end
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (inValid && !dropNow) begin
            dataIn.seq <= seqCount;
            dataIn.key <= inKey;
            dataIn.value <= inValue;
        end
    end

endmodule

// ==== design/recordPipe.sv ====
`timescale 1ns/1ps

`include "pipe_defs.svh"

module recordPipe (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        inValid,
    input  logic [`KEY_WIDTH-1:0]       inKey,
    input  logic [`VALUE_WIDTH-1:0]     inValue,
    input  logic                        outStall,
    output logic                        outValid,
    output logic [`SEQ_WIDTH-1:0]       outSeq,
    output logic [`KEY_WIDTH-1:0]       outKey,
    output logic [`VALUE_WIDTH-1:0]     outValue,
    output pipePkg::sumT                outSum,
    output logic [`FIFO_DEPTH_LOG2-1:0] level,
    output logic [15:0]                 dropCount
);

    logic writeEnable;
    pipePkg::recordT dataIn;
    logic readRequest;
    pipePkg::recordT dataOut;
    logic dataOutValid;

    recordPacker packer_i (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inKey(inKey),
        .inValue(inValue),
        .level(level),
        .writeEnable(writeEnable),
        .dataIn(dataIn),
        .dropCount(dropCount)
    );

    fastFifo #(
        .payloadT(pipePkg::recordT)
    ) fifo_i (
        .clk(clk),
        .rst(rst),
        .writeEnable(writeEnable),
        .dataIn(dataIn),
        .readRequest(readRequest),
        .dataOut(dataOut),
        .dataOutValid(dataOutValid),
        .level(level)       // also feeds the drop decision
    );

    runningSum sum_i (
        .clk(clk),
        .rst(rst),
        .outStall(outStall),
        .dataOutValid(dataOutValid),
        .dataOut(dataOut),
        .readRequest(readRequest),
        .outValid(outValid),
        .outSeq(outSeq),
        .outKey(outKey),
        .outValue(outValue),
        .outSum(outSum)
    );

endmodule

// ==== design/runningSum.sv ====
`timescale 1ns/1ps

`include "pipe_defs.svh"

module runningSum (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    outStall,
    input  logic                    dataOutValid,
    input  pipePkg::recordT         dataOut,
    output logic                    readRequest,
    output logic                    outValid,
    output logic [`SEQ_WIDTH-1:0]   outSeq,
    output logic [`KEY_WIDTH-1:0]   outKey,
    output logic [`VALUE_WIDTH-1:0] outValue,
    output pipePkg::sumT            outSum
);

    // drain whenever downstream is not stalled
    assign readRequest = !outStall;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outValid <= 1'b0;
            outSum <= '0;
        end else begin
            outValid <= dataOutValid;
            if (dataOutValid) begin
                outSum <= outSum + pipePkg::sumT'(dataOut.value); // wraps
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dataOutValid) begin
            outSeq <= dataOut.seq;
            outKey <= dataOut.key;
            outValue <= dataOut.value;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module recordPipeTb -o simv &&
./obj_dir/simv || exit 1

// ==== verif/recordPipeTb.sv ====
`timescale 1ns/1ps

`include "pipe_defs.svh"

module recordPipeTb;

    logic clk = 1'b0;
    logic rst;
    logic inValid;
    logic [`KEY_WIDTH-1:0] inKey;
    logic [`VALUE_WIDTH-1:0] inValue;
    logic outStall;
    logic outValid;
    logic [`SEQ_WIDTH-1:0] outSeq;
    logic [`KEY_WIDTH-1:0] outKey;
    logic [`VALUE_WIDTH-1:0] outValue;
    pipePkg::sumT outSum;
    logic [`FIFO_DEPTH_LOG2-1:0] level;
    logic [15:0] dropCount;

    // stimulus history by sequence number
    logic [`KEY_WIDTH-1:0] keyStore [0:255];
    logic [`VALUE_WIDTH-1:0] valueStore [0:255];

    int unsigned lcgState = 42;
    int seqSent = 0;         // strobes driven so far
    int lastOutFull = -1;    // unwrapped number of the last output
    logic [7:0] lastOutSeq = 8'hFF;
    int emitted = 0;
    bit noGaps = 1'b0;
    logic [`SUM_WIDTH-1:0] expSum = '0;

    recordPipe dut_i (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inKey(inKey),
        .inValue(inValue),
        .outStall(outStall),
        .outValid(outValid),
        .outSeq(outSeq),
        .outKey(outKey),
        .outValue(outValue),
        .outSum(outSum),
        .level(level),
        .dropCount(dropCount)
    );

    always #2 clk = !clk;

    function automatic int unsigned lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // expected total modulo 2^24 after one more record
    function automatic logic [`SUM_WIDTH-1:0] nextSum(input logic [`SUM_WIDTH-1:0] prev,
                                                      input logic [`VALUE_WIDTH-1:0] value);
        logic [`SUM_WIDTH:0] full;
        full = {1'b0, prev} + {9'd0, value};
        return full[`SUM_WIDTH-1:0];
    endfunction

    task automatic failNote(input string what);
        $display("%s at %0t", what, $time);
        $display("Regression failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic reportMismatch(input string signalName, input int unsigned actual,
                                  input int unsigned expected);
        $display("Fail at %0t: %s is %0h, expected %0h", $time, signalName, actual, expected);
        $display("Regression failed");
        $fatal(1, "stopping at first error");
    endtask

    // called just after a falling edge
    task automatic sendOrIdle(input bit wantStrobe);
        int unsigned r;
        logic [7:0] slot;
        if (wantStrobe && (seqSent - (lastOutFull + 1)) < 200) begin
            r = lcgNext();
            slot = seqSent[7:0];
            inValid = 1'b1;
            inKey = r[15:8];
            inValue = r[31:16];
            keyStore[slot] = r[15:8];
            valueStore[slot] = r[31:16];
            seqSent++;
        end else begin
            inValid = 1'b0;
        end
    endtask

    task automatic drainAndSettle();
        int n;
        @(negedge clk);
        inValid = 1'b0;
        outStall = 1'b0;
        repeat (4) @(negedge clk); // writes still in flight
        n = 0;
        while (level != 5'd0 && n < 200) begin
            @(negedge clk);
            n++;
        end
        assert (level == 5'd0) else failNote("FIFO did not drain before the timeout");
        repeat (4) @(negedge clk);
    endtask

    // compares every emitted record against the stored stimulus
    initial begin
        logic [7:0] delta;
        logic [7:0] slot;
        logic [7:0] wantSeq;
        int prevLevel;
        prevLevel = 0;
        forever begin
            @(posedge clk);
            #1;
            if (!rst) begin
                // at most one write and one read per cycle
                assert (int'(level) - prevLevel <= 1 && prevLevel - int'(level) <= 1)
                    else failNote("FIFO level jumped by more than one entry");
                prevLevel = int'(level);
                if (outValid) begin
                    delta = outSeq - lastOutSeq;
                    wantSeq = lastOutSeq + 8'd1;
                    slot = outSeq;
                    assert (delta != 8'd0 && lastOutFull + int'(delta) < seqSent)
                        else failNote("output record was never sent or came out of order");
                    if (noGaps) begin
                        assert (delta == 8'd1)
                            else reportMismatch("outSeq", 32'(outSeq), 32'(wantSeq));
                    end
                    assert (outKey == keyStore[slot])
                        else reportMismatch("outKey", 32'(outKey), 32'(keyStore[slot]));
                    assert (outValue == valueStore[slot])
                        else reportMismatch("outValue", 32'(outValue), 32'(valueStore[slot]));
                    expSum = nextSum(expSum, valueStore[slot]);
                    assert (outSum == expSum)
                        else reportMismatch("outSum", 32'(outSum), 32'(expSum));
                    lastOutFull = lastOutFull + int'(delta);
                    lastOutSeq = outSeq;
                    emitted++;
                end
            end
        end
    end

    initial begin
        int c;
        int unsigned r;
        rst = 1'b1;
        inValid = 1'b0;
        inKey = '0;
        inValue = '0;
        outStall = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        // idle after reset
        repeat (2) @(negedge clk);
        assert (!outValid) else failNote("outValid high after reset");
        assert (level == 5'd0) else reportMismatch("level", 32'(level), 0);
        assert (dropCount == 16'd0) else reportMismatch("dropCount", 32'(dropCount), 0);
        assert (outSum == '0) else reportMismatch("outSum", 32'(outSum), 0);

        // dense input without stall
        noGaps = 1'b1;
        for (c = 0; c < 150; c++) begin
            @(negedge clk);
            sendOrIdle(1'b1);
        end
        drainAndSettle();
        assert (dropCount == 16'd0) else reportMismatch("dropCount", 32'(dropCount), 0);
        assert (emitted == seqSent) else reportMismatch("emitted", emitted, seqSent);
        noGaps = 1'b0;

        // random strobes with bursts of stall
        for (c = 0; c < 400; c++) begin
            @(negedge clk);
            r = lcgNext();
            if (r[31:28] == 4'd0) outStall = !outStall;
            sendOrIdle(r[27:26] != 2'd0);
        end
        drainAndSettle();

        // long stall with input every cycle
        for (c = 0; c < 100; c++) begin
            @(negedge clk);
            outStall = 1'b1;
            sendOrIdle(1'b1);
        end
        @(negedge clk);
        inValid = 1'b0;
        assert (dropCount != 16'd0) else failNote("no records dropped during a long stall");
        drainAndSettle();
        assert (emitted + int'(dropCount) == seqSent)
            else reportMismatch("emitted+dropCount", emitted + int'(dropCount), seqSent);

        // final burst before the pipe goes quiet
        for (c = 0; c < 40; c++) begin
            @(negedge clk);
            outStall = 1'b0;
            sendOrIdle(1'b1);
        end
        drainAndSettle();
        for (c = 0; c < 10; c++) begin
            @(negedge clk);
            assert (!outValid) else failNote("outValid high after the FIFO drained");
        end
        assert (outSum == expSum) else reportMismatch("outSum", 32'(outSum), 32'(expSum));
        assert (emitted + int'(dropCount) == seqSent)
            else reportMismatch("emitted+dropCount", emitted + int'(dropCount), seqSent);

        $display("Regression passed");
        $finish;
    end

endmodule
